/* verilog/uartPkg.sv */
`default_nettype none

package uartPkg;

  // ------------------------------------------------------------
  // CPU register addresses
  // ------------------------------------------------------------
  localparam logic [1:0] ADDR_DATA    = 2'd0;  // RHR on read, THR on write
  localparam logic [1:0] ADDR_STATUS  = 2'd1;  // Status on read, SYN/DLE write ignored
  localparam logic [1:0] ADDR_MODE    = 2'd2;  // Mode registers not kept, reads zero
  localparam logic [1:0] ADDR_COMMAND = 2'd3;  // Command register

  // ------------------------------------------------------------
  // Command register bit positions
  // ------------------------------------------------------------
  localparam int CMD_TX_ENABLE   = 0;  // TxEN
  localparam int CMD_DTR         = 1;  // Force DTR low
  localparam int CMD_RX_ENABLE   = 2;  // RxEN
  localparam int CMD_RESET_ERROR = 4;  // Clears overrun when written as one
  localparam int CMD_RTS         = 5;  // Force RTS low
  localparam int CMD_MODE_LSB    = 6;  // Two-bit operating mode field

  // Operating mode codes
  localparam logic [1:0] MODE_NORMAL      = 2'd0;
  localparam logic [1:0] MODE_LOCAL_LOOP  = 2'd2;  // TXD into receiver
  localparam logic [1:0] MODE_REMOTE_LOOP = 2'd3;  // Received bytes sent back out

  // ------------------------------------------------------------
  // Status register bit positions
  // ------------------------------------------------------------
  localparam int SR_THR_EMPTY = 0;  // THR ready for a new byte
  localparam int SR_RHR_FULL  = 1;  // RHR holds an unread byte
  localparam int SR_TX_EMPTY  = 2;  // Frame finished on TXD
  localparam int SR_OVERRUN   = 4;  // Byte lost in RHR
  localparam int SR_DCD       = 6;  // Inverted DCD pin
  localparam int SR_DSR       = 7;  // Inverted DSR pin

  // Data type shared by every byte path
  typedef logic [7:0] uartByte;

endpackage

`default_nettype wire

/* verilog/serialPkg.sv */
`default_nettype none

package serialPkg;

  // ------------------------------------------------------------
  // Bit timing, all in sysclk cycles
  // ------------------------------------------------------------
  localparam int BIT_CLOCKS = 16;  // One serial bit
  localparam int HALF_BIT   = 8;   // Start bit check point
  localparam int DATA_BITS  = 8;   // 8N1 frames only

  typedef logic [2:0] bitCount;  // Data bit index
  typedef logic [4:0] bitTimer;  // Cycle count within a bit

  // Frame engine states
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txStateT;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateT;

endpackage

`default_nettype wire

/* verilog/busRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

module busRegisters
  import uartPkg::*;
(
  input  logic       sysclk,
  input  logic       s_reset,
  input  logic [1:0] address,
  input  uartByte    dataIn,
  output uartByte    dataOut,
  input  logic       ceN,
  input  logic       readN,
  input  logic       dcdN,
  input  logic       dsrN,
  output logic       txValid,
  output uartByte    txData,
  input  logic       txReady,
  input  logic       txDone,
  input  logic       rxValid,
  input  uartByte    rxData,
  output logic       txEnable,
  output logic       rxEnable,
  output logic       localLoop,
  output logic       dtrN,
  output logic       rtsN,
  output logic       txRdyN,
  output logic       rxRdyN,
  output logic       txEmtN
);

  uartByte    command;     // Command register
  uartByte    status;      // Status register
  uartByte    statusNow;   // Status with live modem bits
  uartByte    rhr;         // Receive holding register
  uartByte    thr;         // Transmit holding register
  uartByte    readLatch;   // Value presented on dataOut
  logic       thrFull;     // THR waiting for the transmitter
  logic       accessDone;  // Access already executed for this ceN low
  logic       access;
  logic       thrWrite;
  logic       remoteLoop;
  logic [1:0] mode;

  // ------------------------------------------------------------
  // CPU access decode
  // ------------------------------------------------------------
  assign access   = !ceN && !accessDone;                       // First cycle of chip enable
  assign thrWrite = access && readN && (address == ADDR_DATA);

  always_ff @(posedge sysclk) begin
    if (!s_reset) begin
      accessDone <= 1'b0;
    end else begin
      accessDone <= !ceN;  // Rearmed once ceN returns high
    end
  end

  assign dataOut = (!ceN && !readN) ? readLatch : '0;

  always_comb begin
    statusNow         = status;
    statusNow[SR_DCD] = !dcdN;
    statusNow[SR_DSR] = !dsrN;
  end

  // ------------------------------------------------------------
  // Command and status registers
  // ------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (!s_reset) begin
      command   <= '0;
      status    <= '0;
      thrFull   <= 1'b0;
      readLatch <= '0;
    end else begin
      if (txValid && txReady) begin  // Byte taken by the transmitter
        thrFull              <= 1'b0;
        status[SR_THR_EMPTY] <= 1'b1;
      end
      if (access) begin
        if (readN) begin
          if (address == ADDR_DATA) begin
            thrFull              <= 1'b1;
            status[SR_THR_EMPTY] <= 1'b0;
          end else if (address == ADDR_COMMAND) begin
            command <= dataIn;
            if (dataIn[CMD_RESET_ERROR]) status[SR_OVERRUN] <= 1'b0;  // Error reset
          end
        end else begin
          case (address)
            ADDR_DATA: begin
              readLatch           <= rhr;
              status[SR_RHR_FULL] <= 1'b0;  // RHR consumed
            end
            ADDR_STATUS: begin
              readLatch           <= statusNow;
              status[SR_TX_EMPTY] <= 1'b0;
            end
            ADDR_MODE:    readLatch <= '0;  // No mode register
            ADDR_COMMAND: readLatch <= command;
          endcase
        end
      end
      if (txDone) status[SR_TX_EMPTY] <= 1'b1;  // Late in block so a read can't hide it
      if (rxValid) begin
        status[SR_RHR_FULL] <= 1'b1;
        if (status[SR_RHR_FULL]) status[SR_OVERRUN] <= 1'b1;  // Previous byte never read
        if (remoteLoop) begin  // Echo straight into THR
          thrFull              <= 1'b1;
          status[SR_THR_EMPTY] <= 1'b0;
        end
      end
    end
  end

  // Transmit and receive holding registers
  always_ff @(posedge sysclk) begin
    if (thrWrite) thr <= dataIn;
    if (rxValid) begin
      rhr <= rxData;
      if (remoteLoop) thr <= rxData;  // Wins over a CPU write on the same edge
    end
  end

  // ------------------------------------------------------------
  // Mode decode and pin outputs
  // ------------------------------------------------------------
  assign mode = command[CMD_MODE_LSB +: 2];

  always_comb begin
    localLoop  = 1'b0;
    remoteLoop = 1'b0;
    case (mode)
      MODE_NORMAL:      ;                    // Plain async operation
      MODE_LOCAL_LOOP:  localLoop  = 1'b1;
      MODE_REMOTE_LOOP: remoteLoop = 1'b1;
      default:          ;                    // Echo mode not kept and runs as normal
    endcase
  end

  assign txEnable = command[CMD_TX_ENABLE];
  assign rxEnable = command[CMD_RX_ENABLE];
  assign dtrN     = !command[CMD_DTR];
  assign rtsN     = !command[CMD_RTS];
  assign txValid  = thrFull;
  assign txData   = thr;

  assign txRdyN = txEnable ? !status[SR_THR_EMPTY] : 1'b1;  // Inactive while TX off
  assign rxRdyN = rxEnable ? !status[SR_RHR_FULL] : 1'b1;   // Inactive while RX off
  assign txEmtN = !status[SR_TX_EMPTY];

endmodule

`default_nettype wire

/* verilog/uartTransmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTransmitter
  import uartPkg::*, serialPkg::*;
(
  input  logic    sysclk,
  input  logic    s_reset,
  input  logic    txEnable,
  input  logic    txValid,
  input  uartByte txData,
  output logic    txReady,
  output logic    txDone,
  output logic    txd
);

  txStateT state;
  bitTimer timer;    // Cycles into the current bit
  bitCount count;    // Data bit being sent
  uartByte shifter;  // Remaining data bits, LSB next
  logic    bitEnd;   // Last cycle of a bit

  assign bitEnd  = (timer == bitTimer'(BIT_CLOCKS - 1));
  assign txReady = txEnable && (state == TX_IDLE);

  // ------------------------------------------------------------
  // Frame sequencing
  // ------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (!s_reset) begin
      state  <= TX_IDLE;
      timer  <= '0;
      count  <= '0;
      txd    <= 1'b1;  // Line idles high
      txDone <= 1'b0;
    end else if (!txEnable) begin  // Disable aborts any frame
      state  <= TX_IDLE;
      timer  <= '0;
      txd    <= 1'b1;
      txDone <= 1'b0;
    end else begin
      txDone <= 1'b0;
      timer  <= bitEnd ? '0 : timer + 1'b1;
      case (state)
        TX_IDLE: begin
          timer <= '0;
          if (txValid) begin  // Transfer edge, start bit begins
            state <= TX_START;
            txd   <= 1'b0;
          end
        end
        TX_START: if (bitEnd) begin
          state <= TX_DATA;
          count <= '0;
          txd   <= shifter[0];  // Bit 0 first
        end
        TX_DATA: if (bitEnd) begin
          if (count == bitCount'(DATA_BITS - 1)) begin
            state <= TX_STOP;
            txd   <= 1'b1;
          end else begin
            count <= count + 1'b1;
            txd   <= shifter[1];  // Next bit, shifter moves on the same edge
          end
        end
        TX_STOP: if (bitEnd) begin
          state  <= TX_IDLE;
          txDone <= 1'b1;  // One cycle pulse
        end
      endcase
    end
  end

  // Payload shift register
  always_ff @(posedge sysclk) begin
    if (txValid && txReady) begin
      shifter <= txData;
    end else if (state == TX_DATA && bitEnd) begin
      shifter <= shifter >> 1;
    end
  end

endmodule

`default_nettype wire

/* verilog/uartReceiver.sv */
`timescale 1ns/1ps
`default_nettype none

module uartReceiver
  import uartPkg::*, serialPkg::*;
(
  input  logic    sysclk,
  input  logic    s_reset,
  input  logic    rxEnable,
  input  logic    localLoop,
  input  logic    rxd,
  input  logic    txd,
  output logic    rxValid,
  output uartByte rxData
);

  rxStateT state;
  bitTimer timer;     // Cycles since the last sample point
  bitCount count;     // Data bit being sampled
  uartByte shifter;   // Assembled byte, filled from the MSB end
  logic    serialIn;  // Selected line
  logic    lastIn;    // Line one cycle ago
  logic    bitEnd;
  logic    halfEnd;

  assign serialIn = localLoop ? txd : rxd;  // Local loopback takes our own TXD
  assign bitEnd   = (timer == bitTimer'(BIT_CLOCKS - 1));
  assign halfEnd  = (timer == bitTimer'(HALF_BIT - 1));
  assign rxData   = shifter;

  // ------------------------------------------------------------
  // Start detection and sample timing
  // ------------------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (!s_reset) begin
      state   <= RX_IDLE;
      timer   <= '0;
      count   <= '0;
      lastIn  <= 1'b1;
      rxValid <= 1'b0;
    end else begin
      lastIn  <= serialIn;
      rxValid <= 1'b0;
      if (!rxEnable) begin
        state <= RX_IDLE;  // Receiver off, drop any frame
        timer <= '0;
      end else begin
        timer <= bitEnd ? '0 : timer + 1'b1;
        case (state)
          RX_IDLE: begin
            timer <= '0;
            if (lastIn && !serialIn) state <= RX_START;  // Falling edge
          end
          RX_START: if (halfEnd) begin
            timer <= '0;  // Now at mid start bit
            count <= '0;
            state <= serialIn ? RX_IDLE : RX_DATA;  // Glitch goes back to idle
          end
          RX_DATA: if (bitEnd) begin
            if (count == bitCount'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end else begin
              count <= count + 1'b1;
            end
          end
          RX_STOP: if (bitEnd) begin  // Mid stop bit, level not checked
            state   <= RX_IDLE;
            rxValid <= 1'b1;
          end
        endcase
      end
    end
  end

  // Mid-bit sampling, LSB arrives first
  always_ff @(posedge sysclk) begin
    if (rxEnable && state == RX_DATA && bitEnd) begin
      shifter <= {serialIn, shifter[7:1]};
    end
  end

endmodule

`default_nettype wire

/* verilog/sc2661Top.sv */
`timescale 1ns/1ps
`default_nettype none

module sc2661Top
  import uartPkg::*;
(
  input  logic       sysclk,
  input  logic       s_reset,
  input  logic [1:0] address,
  input  uartByte    dataIn,
  output uartByte    dataOut,
  input  logic       ceN,
  input  logic       readN,
  input  logic       dcdN,
  input  logic       dsrN,
  input  logic       rxd,
  output logic       txd,
  output logic       dtrN,
  output logic       rtsN,
  output logic       txRdyN,
  output logic       rxRdyN,
  output logic       txEmtN
);

  // ------------------------------------------------------------
  // Internal links
  // ------------------------------------------------------------
  logic    txValid;    // THR handshake
  logic    txReady;
  uartByte txData;
  logic    txDone;     // Frame finished
  logic    rxValid;    // New byte from the receiver
  uartByte rxData;
  logic    txEnable;
  logic    rxEnable;
  logic    localLoop;

  busRegisters regs (
    .sysclk, .s_reset, .address, .dataIn, .dataOut, .ceN, .readN, .dcdN, .dsrN,
    .txValid, .txData, .txReady, .txDone, .rxValid, .rxData,
    .txEnable, .rxEnable, .localLoop, .dtrN, .rtsN, .txRdyN, .rxRdyN, .txEmtN
  );

  uartTransmitter tx (
    .sysclk, .s_reset, .txEnable, .txValid, .txData, .txReady, .txDone,
    .txd                                             // Pin and loopback source
  );

  uartReceiver rx (
    .sysclk, .s_reset, .rxEnable, .localLoop,
    .rxd,
    .txd,                                            // Used only in local loopback
    .rxValid, .rxData
  );

endmodule

`default_nettype wire

/* bench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic sysclk,
  output logic s_reset
);

  localparam int HALF_PERIOD  = 20;  // 40 ns sysclk
  localparam int RESET_CYCLES = 5;

  initial begin
    sysclk = 1'b0;
    forever #HALF_PERIOD sysclk = ~sysclk;
  end

  // Reset held low from time zero, released on a falling edge
  initial begin
    s_reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge sysclk);
    @(negedge sysclk);
    s_reset = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/busRegisters_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module busRegistersAsserts
  import uartPkg::*;
(
  input logic    sysclk,
  input logic    s_reset,
  input logic    ceN,
  input uartByte dataOut,
  input logic    txValid,
  input uartByte txData,
  input logic    txReady,
  input logic    txEnable,
  input logic    txRdyN
);

  // ------------------------------------------------------------
  // THR to transmitter handshake
  // ------------------------------------------------------------
  property holdUntilReady;
    @(posedge sysclk) disable iff (!s_reset)
      (txValid && !txReady) |=> (txValid && $stable(txData));  // Offer stays put
  endproperty

  validHeld: assert property (holdUntilReady)
    else $error("txValid dropped or txData changed before txReady");

  // ------------------------------------------------------------
  // Pin behavior
  // ------------------------------------------------------------
  txRdyIdle: assert property (@(posedge sysclk) disable iff (!s_reset) !txEnable |-> txRdyN)
    else $error("txRdyN active while the transmitter is disabled");

  dataOutIdle: assert property (@(posedge sysclk) disable iff (!s_reset) ceN |-> dataOut == '0)
    else $error("dataOut not zero with chip enable inactive");

endmodule

bind busRegisters busRegistersAsserts checks (
  .sysclk, .s_reset, .ceN, .dataOut, .txValid, .txData, .txReady, .txEnable, .txRdyN
);

`default_nettype wire

/* bench/uartTb.sv */
`timescale 1ns/1ps
`default_nettype none

module uartTb
  import uartPkg::*, serialPkg::*;
();

  // Record opcodes, top nibble of each data file word
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;
  localparam logic [3:0] OP_SEND   = 4'h3;
  localparam logic [3:0] OP_EXPECT = 4'h4;
  localparam logic [3:0] OP_PINS   = 4'h5;
  localparam logic [3:0] OP_END    = 4'hF;
  localparam int MAX_RECORDS       = 64;
  localparam int CYCLES_PER_RECORD = 400;  // Worst record is one frame plus slack
  localparam int MARGIN_CYCLES     = 200;
  localparam int CLOCK_NS          = 40;

  logic        sysclk;
  logic        s_reset;
  logic [1:0]  address;
  uartByte     dataIn;
  uartByte     dataOut;
  logic        ceN;
  logic        readN;
  logic        dcdN;
  logic        dsrN;
  logic        rxd;
  logic        txd;
  logic        dtrN;
  logic        rtsN;
  logic        txRdyN;
  logic        rxRdyN;
  logic        txEmtN;
  logic [15:0] records [MAX_RECORDS];  // {opcode, address, data}
  uartByte     txFrames [$];           // Bytes decoded from TXD, oldest first
  int          numRecords;

  clockGen clocks (.sysclk, .s_reset);

  sc2661Top DUT (
    .sysclk, .s_reset, .address, .dataIn, .dataOut, .ceN, .readN, .dcdN, .dsrN,
    .rxd, .txd, .dtrN, .rtsN, .txRdyN, .rxRdyN, .txEmtN
  );

  // ------------------------------------------------------------
  // Failure handling and compare
  // ------------------------------------------------------------
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic compareValue(input string name, input uartByte expected, input uartByte actual);
    if (actual !== expected) begin
      abortRun($sformatf("Error at %0d ns: %s expected 0x%02h, actual 0x%02h",
                         $time, name, expected, actual));
    end
  endtask

  // ------------------------------------------------------------
  // CPU port, one access per chip enable
  // ------------------------------------------------------------
  task automatic cpuWrite(input logic [1:0] addr, input uartByte value);
    @(negedge sysclk);
    address = addr;
    dataIn  = value;
    readN   = 1'b1;
    ceN     = 1'b0;
    @(negedge sysclk);  // Executed on the rising edge between
    ceN     = 1'b1;
  endtask

  task automatic cpuRead(input logic [1:0] addr, input uartByte expected);
    @(negedge sysclk);
    address = addr;
    readN   = 1'b0;
    ceN     = 1'b0;
    @(negedge sysclk);  // Read latch loaded, dataOut settled
    compareValue($sformatf("dataOut(address %0d)", addr), expected, dataOut);
    ceN     = 1'b1;
    readN   = 1'b1;
  endtask

  // ------------------------------------------------------------
  // Serial side
  // ------------------------------------------------------------
  task automatic sendFrame(input uartByte value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};  // Start first, LSB first, stop last
    for (int i = 0; i < 10; i++) begin
      @(negedge sysclk);
      rxd = frame[i];
      repeat (BIT_CLOCKS - 1) @(negedge sysclk);
    end
  endtask

  task automatic expectTx(input uartByte expected);
    uartByte got;
    while (txFrames.size() == 0) @(negedge sysclk);  // Watchdog bounds this
    got = txFrames.pop_front();
    compareValue("txd frame", expected, got);
    repeat (2) @(negedge sysclk);  // txDone reaches SR2 a cycle later
  endtask

  task automatic checkPins(input uartByte expected);
    @(negedge sysclk);
    compareValue("{txEmtN,rxRdyN,txRdyN,rtsN,dtrN,txd}", expected,
                 {2'b00, txEmtN, rxRdyN, txRdyN, rtsN, dtrN, txd});
  endtask

  // TXD decoder, mid-bit samples taken on falling edges
  initial begin : txMonitor
    uartByte captured;
    wait (s_reset === 1'b1);
    forever begin
      do @(negedge sysclk); while (txd !== 1'b0);  // Start bit begins
      repeat (HALF_BIT) @(negedge sysclk);
      if (txd !== 1'b0) abortRun("TXD start bit ended early");
      for (int i = 0; i < DATA_BITS; i++) begin
        repeat (BIT_CLOCKS) @(negedge sysclk);
        captured[i] = txd;
      end
      repeat (BIT_CLOCKS) @(negedge sysclk);
      if (txd !== 1'b1) abortRun("TXD stop bit was not high");
      repeat (HALF_BIT) @(negedge sysclk);  // End of stop bit
      txFrames.push_back(captured);
    end
  end

  // Time limit follows the record count
  initial begin : watchdog
    wait (s_reset === 1'b1);
    #((numRecords * CYCLES_PER_RECORD + MARGIN_CYCLES) * CLOCK_NS);
    abortRun("Timeout: the data file did not finish in the allowed time");
  end

  // ------------------------------------------------------------
  // Record player
  // ------------------------------------------------------------
  initial begin : stimulus
    logic [15:0] rec;
    address = '0;
    dataIn  = '0;
    ceN     = 1'b1;
    readN   = 1'b1;
    dcdN    = 1'b0;  // Carrier present, SR6 reads one
    dsrN    = 1'b1;  // SR7 reads zero
    rxd     = 1'b1;  // Line idle
    $readmemh("bench/uartInput.txt", records);
    numRecords = 0;
    while (numRecords < MAX_RECORDS && records[numRecords][15:12] != OP_END) begin
      numRecords++;
    end
    wait (s_reset === 1'b1);
    for (int i = 0; i < numRecords; i++) begin
      rec = records[i];
      case (rec[15:12])
        OP_WRITE:  cpuWrite(rec[9:8], rec[7:0]);
        OP_READ:   cpuRead(rec[9:8], rec[7:0]);
        OP_SEND:   sendFrame(rec[7:0]);
        OP_EXPECT: expectTx(rec[7:0]);
        OP_PINS:   checkPins(rec[7:0]);
        default:   abortRun($sformatf("Unknown opcode %0h in record %0d", rec[15:12], i));
      endcase
    end
    if (numRecords == 0 || txFrames.size() != 0) begin
      abortRun("No records were read, or a TXD frame was never checked");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/uartInput.txt */
// Columns: opcode_address_data, one hex word per record; opcodes 1 write, 2 read (data expected),
// 3 send on rxd, 4 expect on txd, 5 pins {txEmtN,rxRdyN,txRdyN,rtsN,dtrN,txd}, F end
5_0_3F  // Reset, all control outputs high
2_3_00  // Command register cleared
1_3_22  // DTR and RTS bits
2_3_22
5_0_39  // dtrN and rtsN low
1_3_01  // TX enable only
1_0_A5
4_0_A5
5_0_17  // txRdyN and txEmtN low
2_1_45  // SR0, SR2, SR6
2_1_41  // SR2 cleared by the read
1_3_05  // TX and RX enable
3_0_C3
5_0_27  // rxRdyN low
2_0_C3
5_0_37  // rxRdyN back high
3_0_5A  // Two frames, no read between
3_0_96
2_1_53  // Overrun set
1_3_15  // Error reset
2_1_43
2_0_96  // Newer byte kept
1_3_85  // Local loopback
1_0_6E
4_0_6E
2_1_47  // SR1 set by the looped byte
2_0_6E
1_3_C5  // Remote loopback
3_0_39
4_0_39  // Echoed unchanged
2_1_47
F_0_00

/* sc2661Top.f */
verilog/uartPkg.sv
verilog/serialPkg.sv
verilog/busRegisters.sv
verilog/uartTransmitter.sv
verilog/uartReceiver.sv
verilog/sc2661Top.sv
bench/clockGen.sv
bench/busRegisters_asserts.sv
bench/uartTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the sc2661Top testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module uartTb -f sc2661Top.f -o uartSim

./obj_dir/uartSim 2>&1 | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL, see sim.log"
  exit 1
fi
